// File: design/ifetch_defs.svh
`ifndef IFETCH_DEFS_SVH
`define IFETCH_DEFS_SVH

// Instruction and address widths
`define IF_WORD_SIZE 32
`define IF_ADDR_SIZE 32

// Cache geometry, direct mapped
`define IC_LINE_WORDS 4
`define IC_LINES 16

// Byte offset within a line and line index
`define IC_OFFSET_BITS 4
`define IC_INDEX_BITS 4

// Remaining upper address bits form the tag
`define IC_TAG_BITS (`IF_ADDR_SIZE - `IC_INDEX_BITS - `IC_OFFSET_BITS)

// Whole line as carried by the memory port and the fill path
`define IC_LINE_BITS (`IC_LINE_WORDS * `IF_WORD_SIZE)

`endif

// File: design/ifetch_isa_pkg.sv
`default_nettype none

`include "ifetch_defs.svh"

package ifetch_isa_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // addi x0, x0, 0
    localparam logic [`IF_WORD_SIZE-1:0] NOP_INSTR = 32'h0000_0013;

    function automatic logic is_ctrl_transfer(input logic [`IF_WORD_SIZE-1:0] instr);
        opcode_e op;
        op = opcode_e'(instr[6:0]);
        return op inside {BRANCH, JAL, JALR};
    endfunction

endpackage

`default_nettype wire

// File: design/ifetch_cache_pkg.sv
`default_nettype none

`include "ifetch_defs.svh"

package ifetch_cache_pkg;

    typedef enum logic [1:0] {
        FS_RUN,
        FS_MISS,
        FS_BRANCH
    } fetch_state_e;

    // PC generator to cache
    typedef struct packed {
        logic                     valid;
        logic                     hold;
        logic [`IF_ADDR_SIZE-1:0] pc;
    } ic_req_t;

    // Registered cache response
    typedef struct packed {
        logic                     valid;
        logic                     miss;
        logic [`IF_ADDR_SIZE-1:0] pc;
        logic [`IF_WORD_SIZE-1:0] instr;
    } ic_resp_t;

    // Cache to refill controller, start is a one-cycle strobe
    typedef struct packed {
        logic                     start;
        logic [`IF_ADDR_SIZE-1:0] line_addr;
    } refill_req_t;

    // Refill controller to cache
    typedef struct packed {
        logic                      we;
        logic [`IC_INDEX_BITS-1:0] index;
        logic [`IC_TAG_BITS-1:0]   tag;
        logic [`IC_LINE_BITS-1:0]  data;
    } line_fill_t;

    // Fetch unit to decode
    typedef struct packed {
        logic                     valid;
        logic [`IF_ADDR_SIZE-1:0] pc;
        logic [`IF_WORD_SIZE-1:0] instr;
    } fetch_out_t;

endpackage

`default_nettype wire

// File: design/pc_gen.sv
`default_nettype none

`include "ifetch_defs.svh"

module pc_gen
    import ifetch_isa_pkg::*, ifetch_cache_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     reset_i,
    input  wire logic                     hazard_i,
    input  wire logic                     branch_done_i,
    input  wire logic                     redirect_i,
    input  wire logic [`IF_ADDR_SIZE-1:0] target_i,
    input  wire ic_resp_t                 ic_resp_i,
    input  wire logic                     fill_done_i,
    output ic_req_t                       ic_req_o
);

    localparam logic [`IF_ADDR_SIZE-1:0] INSTR_BYTES = 4;

    fetch_state_e state_q, state_d;

    logic [`IF_ADDR_SIZE-1:0] pc_q, pc_d;
    logic [`IF_ADDR_SIZE-1:0] fall_q, fall_d;

    // Response in this cycle belongs to a request sent last cycle
    logic sent_q;
    logic take_miss;
    logic take_ctrl;
    logic req_valid;

    // A held response is acted on only once, in its first cycle
    assign take_miss = sent_q && ic_resp_i.miss;
    assign take_ctrl = sent_q && ic_resp_i.valid && is_ctrl_transfer(ic_resp_i.instr);

    assign req_valid = (state_q == FS_RUN) && !hazard_i && !take_miss && !take_ctrl;

    assign ic_req_o.valid = req_valid;
    assign ic_req_o.hold  = hazard_i;
    assign ic_req_o.pc    = pc_q;

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        fall_d  = fall_q;
        unique case (state_q)
            FS_RUN: begin
                if (take_miss) begin
                    // Refetch the missed word once the line is in
                    state_d = FS_MISS;
                    pc_d    = ic_resp_i.pc;
                end else if (take_ctrl) begin
                    state_d = FS_BRANCH;
                    fall_d  = ic_resp_i.pc + INSTR_BYTES;
                end else if (req_valid) begin
                    pc_d = pc_q + INSTR_BYTES;
                end
            end
            FS_MISS: begin
                if (fill_done_i) begin
                    state_d = FS_RUN;
                end
            end
            FS_BRANCH: begin
                // Issue waits for the hazard to drop in FS_RUN
                if (branch_done_i) begin
                    state_d = FS_RUN;
                    pc_d    = redirect_i ? target_i : fall_q;
                end
            end
            default: begin
                state_d = FS_RUN;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= FS_RUN;
            pc_q    <= '0;
            sent_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            sent_q  <= req_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        fall_q <= fall_d;
    end

endmodule

`default_nettype wire

// File: design/icache.sv
`default_nettype none

`include "ifetch_defs.svh"

module icache
    import ifetch_isa_pkg::*, ifetch_cache_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       reset_i,
    input  wire ic_req_t    ic_req_i,
    input  wire line_fill_t line_fill_i,
    output ic_resp_t        ic_resp_o,
    output refill_req_t     refill_o
);

    localparam int INDEX_LSB = `IC_OFFSET_BITS;
    localparam int TAG_LSB   = `IC_OFFSET_BITS + `IC_INDEX_BITS;

    // Storage
    logic [`IC_LINES-1:0]      valid_q;
    logic [`IC_TAG_BITS-1:0]   tag_q  [`IC_LINES];
    logic [`IC_LINE_WORDS-1:0][`IF_WORD_SIZE-1:0] data_q [`IC_LINES];

    // Lookup fields of the incoming request
    logic [`IC_INDEX_BITS-1:0]    req_index;
    logic [`IC_TAG_BITS-1:0]      req_tag;
    logic [`IC_OFFSET_BITS-3:0]   req_word;
    logic                         hit;
    logic [`IF_WORD_SIZE-1:0]     hit_word;
    logic [`IF_ADDR_SIZE-1:0]     req_line_addr;

    ic_resp_t    resp_q;
    refill_req_t refill_q;

    assign req_index = ic_req_i.pc[TAG_LSB-1:INDEX_LSB];
    assign req_tag   = ic_req_i.pc[`IF_ADDR_SIZE-1:TAG_LSB];
    assign req_word  = ic_req_i.pc[`IC_OFFSET_BITS-1:2];

    assign hit      = valid_q[req_index] && (tag_q[req_index] == req_tag);
    assign hit_word = data_q[req_index][req_word];

    assign req_line_addr = {ic_req_i.pc[`IF_ADDR_SIZE-1:INDEX_LSB], {`IC_OFFSET_BITS{1'b0}}};

    // Response register, frozen while hold is high
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            resp_q.valid <= 1'b0;
            resp_q.miss  <= 1'b0;
            resp_q.pc    <= '0;
            resp_q.instr <= NOP_INSTR;
        end else if (!ic_req_i.hold) begin
            resp_q.valid <= ic_req_i.valid && hit;
            resp_q.miss  <= ic_req_i.valid && !hit;
            resp_q.pc    <= ic_req_i.pc;
            resp_q.instr <= (ic_req_i.valid && hit) ? hit_word : NOP_INSTR;
        end
    end

    // Refill start lasts one cycle even if the miss response is held
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            refill_q.start <= 1'b0;
        end else begin
            refill_q.start <= ic_req_i.valid && !hit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ic_req_i.valid && !hit) begin
            refill_q.line_addr <= req_line_addr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (line_fill_i.we) begin
            valid_q[line_fill_i.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (line_fill_i.we) begin
            tag_q[line_fill_i.index]  <= line_fill_i.tag;
            data_q[line_fill_i.index] <= line_fill_i.data;
        end
    end

    assign ic_resp_o = resp_q;
    assign refill_o  = refill_q;

endmodule

`default_nettype wire

// File: design/refill_ctrl.sv
`default_nettype none

`include "ifetch_defs.svh"

module refill_ctrl
    import ifetch_cache_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     reset_i,
    input  wire refill_req_t              refill_i,
    input  wire logic                     mem_valid_i,
    input  wire logic [`IC_LINE_BITS-1:0] mem_line_i,
    output logic                          mem_req_o,
    output logic [`IF_ADDR_SIZE-1:0]      mem_addr_o,
    output line_fill_t                    line_fill_o,
    output logic                          fill_done_o
);

    localparam int TAG_LSB = `IC_OFFSET_BITS + `IC_INDEX_BITS;

    typedef enum logic {
        RF_IDLE,
        RF_WAIT
    } rf_state_e;

    rf_state_e state_q;

    logic                     req_q;
    logic                     fill_q;
    logic [`IF_ADDR_SIZE-1:0] addr_q;
    logic [`IC_LINE_BITS-1:0] line_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= RF_IDLE;
            req_q   <= 1'b0;
            fill_q  <= 1'b0;
        end else begin
            req_q  <= 1'b0;
            fill_q <= 1'b0;
            unique case (state_q)
                RF_IDLE: begin
                    if (refill_i.start) begin
                        state_q <= RF_WAIT;
                        req_q   <= 1'b1;
                    end
                end
                RF_WAIT: begin
                    // Latency is set by the memory
                    if (mem_valid_i) begin
                        state_q <= RF_IDLE;
                        fill_q  <= 1'b1;
                    end
                end
                default: state_q <= RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RF_IDLE && refill_i.start) begin
            addr_q <= refill_i.line_addr;
        end
        if (state_q == RF_WAIT && mem_valid_i) begin
            line_q <= mem_line_i;
        end
    end

    assign mem_req_o  = req_q;
    assign mem_addr_o = addr_q;

    assign line_fill_o.we    = fill_q;
    assign line_fill_o.index = addr_q[TAG_LSB-1:`IC_OFFSET_BITS];
    assign line_fill_o.tag   = addr_q[`IF_ADDR_SIZE-1:TAG_LSB];
    assign line_fill_o.data  = line_q;

    // Cache is written on this same edge
    assign fill_done_o = fill_q;

endmodule

`default_nettype wire

// File: design/ifetch_top.sv
`default_nettype none

`include "ifetch_defs.svh"

module ifetch_top
    import ifetch_cache_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     reset_i,
    input  wire logic                     hazard_i,
    input  wire logic                     branch_done_i,
    input  wire logic                     redirect_i,
    input  wire logic [`IF_ADDR_SIZE-1:0] target_i,
    input  wire logic                     mem_valid_i,
    input  wire logic [`IC_LINE_BITS-1:0] mem_line_i,
    output fetch_out_t                    fetch_o,
    output logic                          mem_req_o,
    output logic [`IF_ADDR_SIZE-1:0]      mem_addr_o
);

    ic_req_t     ic_req;
    ic_resp_t    ic_resp;
    refill_req_t refill;
    line_fill_t  line_fill;
    logic        fill_done;

    pc_gen u_pc_gen (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .hazard_i      (hazard_i),
        .branch_done_i (branch_done_i),
        .redirect_i    (redirect_i),
        .target_i      (target_i),
        .ic_resp_i     (ic_resp),
        .fill_done_i   (fill_done),
        .ic_req_o      (ic_req)
    );

    icache u_icache (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .ic_req_i    (ic_req),
        .line_fill_i (line_fill),
        .ic_resp_o   (ic_resp),
        .refill_o    (refill)
    );

    refill_ctrl u_refill_ctrl (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .refill_i    (refill),
        .mem_valid_i (mem_valid_i),
        .mem_line_i  (mem_line_i),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .line_fill_o (line_fill),
        .fill_done_o (fill_done)
    );

    // Decode sees the registered cache response
    assign fetch_o.valid = ic_resp.valid;
    assign fetch_o.pc    = ic_resp.pc;
    assign fetch_o.instr = ic_resp.instr;

endmodule

`default_nettype wire

// File: testbench/imem_model.sv
`default_nettype none

`include "ifetch_defs.svh"

module imem_model
    import ifetch_isa_pkg::*;
#(
    parameter int LAT_MIN = 2,
    parameter int LAT_MAX = 6
) (
    input  wire logic                     clk_i,
    input  wire logic                     reset_i,
    input  wire logic                     mem_req_i,
    input  wire logic [`IF_ADDR_SIZE-1:0] mem_addr_i,
    output logic                          mem_valid_o,
    output logic [`IC_LINE_BITS-1:0]      mem_line_o
);

    logic                     busy;
    logic [`IF_ADDR_SIZE-1:0] addr_q;
    int                       wait_q;

    // Hashed upper bits with the opcode from address bits 6:2
    function automatic logic [`IF_WORD_SIZE-1:0] mem_word(input logic [`IF_ADDR_SIZE-1:0] addr);
        logic [31:0] h;
        opcode_e     op;
        h = (addr ^ 32'h3c6e_f372) * 32'h0019_660d;
        if (addr[6:2] == 5'd7) begin
            op = BRANCH;
        end else if (addr[6:2] == 5'd23) begin
            op = JAL;
        end else begin
            op = OP_IMM;
        end
        return {h[31:7], op};
    endfunction

    initial begin
        mem_valid_o = 1'b0;
        mem_line_o  = '0;
        busy        = 1'b0;
        wait_q      = 0;
    end

    always @(posedge clk_i) begin
        mem_valid_o <= 1'b0;
        if (reset_i) begin
            busy <= 1'b0;
        end else if (mem_req_i) begin
            busy   <= 1'b1;
            addr_q <= mem_addr_i;
            // Count starts in the cycle after the request
            wait_q <= LAT_MIN - 1 + int'($urandom % 32'(LAT_MAX - LAT_MIN + 1));
        end else if (busy) begin
            if (wait_q <= 1) begin
                busy        <= 1'b0;
                mem_valid_o <= 1'b1;
                for (int w = 0; w < `IC_LINE_WORDS; w++) begin
                    mem_line_o[w*`IF_WORD_SIZE +: `IF_WORD_SIZE] <= mem_word(addr_q + 32'(4 * w));
                end
            end else begin
                wait_q <= wait_q - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/ifetch_tb.sv
`default_nettype none

`include "ifetch_defs.svh"

module ifetch_tb
    import ifetch_isa_pkg::*, ifetch_cache_pkg::*;
;

    localparam int NUM_TESTS   = 5;
    localparam int FETCHES     = 300;
    // Worst case per fetch is a full miss at the longest latency plus a branch wait
    localparam int CYCLE_LIMIT = NUM_TESTS * FETCHES * 13 + 500;

    logic                     clk_i;
    logic                     reset_i;
    logic                     hazard_i;
    logic                     branch_done_i;
    logic                     redirect_i;
    logic [`IF_ADDR_SIZE-1:0] target_i;
    logic                     mem_valid;
    logic [`IC_LINE_BITS-1:0] mem_line;
    fetch_out_t               fetch;
    logic                     mem_req;
    logic [`IF_ADDR_SIZE-1:0] mem_addr;

    string test_name [NUM_TESTS] = '{"sequential_hits", "refill", "branch_redirect",
                                     "conflict_eviction", "hazard_hold"};
    int    hazard_pct   [NUM_TESTS] = '{0, 0, 0, 0, 25};
    int    redirect_pct [NUM_TESTS] = '{70, 30, 50, 80, 50};
    int    alias_pct    [NUM_TESTS] = '{0, 0, 0, 60, 20};

    int test_idx;
    int cycles;
    int fetch_count;
    int errors;
    int checks;
    int test_errors [NUM_TESTS];
    int refills     [NUM_TESTS];
    int evictions   [NUM_TESTS];

    // Reference state
    logic [`IF_ADDR_SIZE-1:0] exp_pc;
    logic [`IF_ADDR_SIZE-1:0] ctrl_pc;
    logic [`IF_ADDR_SIZE-1:0] br_next_pc;
    int                       ctrl_count;
    int                       done_count;
    int                       applied_count;
    logic [`IC_LINES-1:0]     mirror_valid;
    logic [`IC_TAG_BITS-1:0]  mirror_tag [`IC_LINES];
    fetch_out_t               prev_fetch;
    logic                     prev_hazard;
    logic                     prev_reset;

    // Driver state
    int   haz_left;
    int   br_delay;
    logic delay_set;

    ifetch_top UUT (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .hazard_i      (hazard_i),
        .branch_done_i (branch_done_i),
        .redirect_i    (redirect_i),
        .target_i      (target_i),
        .mem_valid_i   (mem_valid),
        .mem_line_i    (mem_line),
        .fetch_o       (fetch),
        .mem_req_o     (mem_req),
        .mem_addr_o    (mem_addr)
    );

    imem_model #(.LAT_MIN(2), .LAT_MAX(6)) u_imem (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .mem_req_i   (mem_req),
        .mem_addr_i  (mem_addr),
        .mem_valid_o (mem_valid),
        .mem_line_o  (mem_line)
    );

    function automatic logic [`IF_WORD_SIZE-1:0] expected_word(
        input logic [`IF_ADDR_SIZE-1:0] addr
    );
        logic [31:0] h;
        logic [6:0]  op;
        h = (addr ^ 32'h3c6e_f372) * 32'h0019_660d;
        op = (addr[6:2] == 5'd7) ? 7'b1100011 : (addr[6:2] == 5'd23) ? 7'b1101111 : 7'b0010011;
        return {h[31:7], op};
    endfunction

    function automatic logic is_ctrl_addr(input logic [`IF_ADDR_SIZE-1:0] addr);
        return (addr[6:2] == 5'd7) || (addr[6:2] == 5'd23);
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail %s %s: expected %h, actual %h", test_name[test_idx], what, exp, act);
        errors++;
        test_errors[test_idx]++;
    endtask

    task automatic record_failure(input string msg);
        $display("Error in %s: %s", test_name[test_idx], msg);
        errors++;
        test_errors[test_idx]++;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d fetches checked", cycles, fetch_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Decode and execute side stimulus
    always @(posedge clk_i) begin
        if (reset_i) begin
            hazard_i      <= 1'b0;
            branch_done_i <= 1'b0;
        end else begin
            branch_done_i <= 1'b0;
            if (haz_left > 0) begin
                hazard_i <= 1'b1;
                haz_left = haz_left - 1;
            end else if (int'($urandom % 100) < hazard_pct[test_idx]) begin
                hazard_i <= 1'b1;
                haz_left = int'($urandom % 4);
            end else begin
                hazard_i <= 1'b0;
            end
            if (ctrl_count != done_count) begin
                if (!delay_set) begin
                    br_delay  = int'($urandom % 5);
                    delay_set = 1'b1;
                end else if (br_delay == 0) begin
                    logic                     redir;
                    logic [`IF_ADDR_SIZE-1:0] tgt;
                    logic [3:0]               idx;
                    logic [1:0]               tag2;
                    redir = int'($urandom % 100) < redirect_pct[test_idx];
                    if (int'($urandom % 100) < alias_pct[test_idx]) begin
                        // Same index as a cached line but another tag
                        idx  = 4'($urandom);
                        tag2 = mirror_valid[idx] ? mirror_tag[idx][1:0] + 2'd1 : 2'($urandom);
                        tgt  = {22'b0, tag2, idx, 2'($urandom), 2'b00};
                    end else begin
                        tgt = {22'b0, 8'($urandom), 2'b00};
                    end
                    branch_done_i <= 1'b1;
                    redirect_i    <= redir;
                    target_i      <= tgt;
                    br_next_pc = redir ? tgt : ctrl_pc + 32'd4;
                    delay_set  = 1'b0;
                    done_count = done_count + 1;
                end else begin
                    br_delay = br_delay - 1;
                end
            end
        end
    end

    // Compare on the falling edge where all outputs are settled
    always @(negedge clk_i) begin
        logic [`IC_INDEX_BITS-1:0] idx;
        logic [`IC_TAG_BITS-1:0]   tag;
        if (applied_count != done_count) begin
            exp_pc        = br_next_pc;
            applied_count = done_count;
        end
        if (reset_i || prev_reset) begin
            checks++;
            if (fetch.valid || mem_req) begin
                record_failure("fetch valid or memory request during reset");
            end
        end else begin
            if (prev_hazard) begin
                checks++;
                if (fetch.valid != prev_fetch.valid) begin
                    report_mismatch("held fetch valid", 32'(prev_fetch.valid), 32'(fetch.valid));
                end
                if (fetch.pc != prev_fetch.pc) begin
                    report_mismatch("held fetch pc", prev_fetch.pc, fetch.pc);
                end
                if (fetch.instr != prev_fetch.instr) begin
                    report_mismatch("held fetch instr", prev_fetch.instr, fetch.instr);
                end
            end
            if (mem_req) begin
                idx = mem_addr[`IC_OFFSET_BITS +: `IC_INDEX_BITS];
                tag = mem_addr[`IF_ADDR_SIZE-1:`IC_OFFSET_BITS+`IC_INDEX_BITS];
                refills[test_idx]++;
                checks++;
                if (mem_addr != {exp_pc[`IF_ADDR_SIZE-1:`IC_OFFSET_BITS], 4'b0}) begin
                    report_mismatch("refill address", {exp_pc[31:4], 4'b0}, mem_addr);
                end
                if (mirror_valid[idx] && mirror_tag[idx] == tag) begin
                    record_failure("refill of a line that is already cached");
                end else if (mirror_valid[idx]) begin
                    evictions[test_idx]++;
                end
                mirror_valid[idx] = 1'b1;
                mirror_tag[idx]   = tag;
            end
            if (fetch.valid && !hazard_i) begin
                idx = exp_pc[`IC_OFFSET_BITS +: `IC_INDEX_BITS];
                tag = exp_pc[`IF_ADDR_SIZE-1:`IC_OFFSET_BITS+`IC_INDEX_BITS];
                fetch_count++;
                checks++;
                if (ctrl_count != done_count) begin
                    record_failure("valid fetch during a branch stall");
                end
                if (fetch.pc != exp_pc) begin
                    report_mismatch("pc", exp_pc, fetch.pc);
                end
                if (fetch.instr != expected_word(exp_pc)) begin
                    report_mismatch("instr", expected_word(exp_pc), fetch.instr);
                end
                if (!mirror_valid[idx] || mirror_tag[idx] != tag) begin
                    record_failure("hit on a line that was never refilled");
                end
                if (is_ctrl_addr(exp_pc)) begin
                    ctrl_pc    = exp_pc;
                    ctrl_count = ctrl_count + 1;
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
            end
        end
        prev_fetch  = fetch;
        prev_hazard = hazard_i;
        prev_reset  = reset_i;
    end

    initial begin
        int failed_tests;
        void'($urandom(32'hffaf_300b));
        reset_i       = 1'b1;
        hazard_i      = 1'b0;
        branch_done_i = 1'b0;
        redirect_i    = 1'b0;
        target_i      = '0;
        test_idx      = 0;
        cycles        = 0;
        fetch_count   = 0;
        errors        = 0;
        checks        = 0;
        exp_pc        = '0;
        ctrl_pc       = '0;
        br_next_pc    = '0;
        ctrl_count    = 0;
        done_count    = 0;
        applied_count = 0;
        mirror_valid  = '0;
        prev_fetch    = '0;
        prev_hazard   = 1'b0;
        prev_reset    = 1'b1;
        haz_left      = 0;
        br_delay      = 0;
        delay_set     = 1'b0;
        failed_tests  = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors[t] = 0;
            refills[t]     = 0;
            evictions[t]   = 0;
        end
        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_idx = t;
            wait (fetch_count >= (t + 1) * FETCHES);
            if (test_errors[t] != 0) begin
                failed_tests++;
            end
            $display("Test %0d %s: %0d refills, %0d evictions, %0d errors, %s", t,
                     test_name[t], refills[t], evictions[t], test_errors[t],
                     (test_errors[t] == 0) ? "ok" : "failed");
        end
        $display("Tests: %0d run, %0d failed; checks: %0d; errors: %0d",
                 NUM_TESTS, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ifetch.f
+incdir+design
design/ifetch_isa_pkg.sv
design/ifetch_cache_pkg.sv
design/pc_gen.sv
design/icache.sv
design/refill_ctrl.sv
design/ifetch_top.sv
testbench/imem_model.sv
testbench/ifetch_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ifetch_tb
FILELIST  ?= ifetch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) design/ifetch_defs.svh

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
